//--- sources.f
hdl/cache_pkg.sv
hdl/dir_access_if.sv
hdl/req_capture.sv
hdl/tag_state_array.sv
hdl/lru_ages.sv
hdl/mesi_ctrl.sv
hdl/resp_fifo.sv
hdl/l2_mesi_cache.sv
dv/tb_clk_gen.sv
dv/tb_l2_mesi_cache.sv

//--- Makefile
TOP = tb_l2_mesi_cache

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f sources.f -o sim

run: compile
	@out="$$(./obj_dir/sim)"; echo "$$out"; echo "$$out" | grep -q "^STATUS: PASS$$"

clean:
	rm -rf obj_dir

//--- dv/tb_l2_mesi_cache.sv
`timescale 1ns/100ps

module tb_l2_mesi_cache;

	localparam int N_RAND = 400;
	// requests per test, in run order
	localparam int N_REQ  = 5 + 3 + 11 + 11 + N_RAND + 5 + 7;
	localparam int N_CLR  = 1;

	logic clk;
	logic arst_n;
	logic req_valid;
	logic req_ready;
	cache_pkg::cache_op_e req_op;
	logic [31:0] req_addr;
	logic resp_valid;
	logic resp_ready;
	cache_pkg::cache_op_e resp_op;
	logic resp_hit;
	cache_pkg::way_t resp_way;
	cache_pkg::snoop_e resp_snoop;
	cache_pkg::mesi_e resp_state;
	logic [31:0] resp_addr;
	logic [15:0] hit_count;
	logic [15:0] miss_count;

	// model of tags, states and ages
	cache_pkg::tag_t  m_tag   [cache_pkg::NUM_SETS][cache_pkg::NUM_WAYS];
	cache_pkg::mesi_e m_state [cache_pkg::NUM_SETS][cache_pkg::NUM_WAYS];
	int               m_age   [cache_pkg::NUM_SETS][cache_pkg::NUM_WAYS];
	int               m_hits;
	int               m_misses;
	cache_pkg::resp_t exp_q [$];

	logic [31:0] rng;
	logic [31:0] rdy_rng;
	logic        hold;
	int          errors;
	int          checks;
	int          tests;

	tb_clk_gen u_clk (.clk(clk), .arst_n(arst_n));

	l2_mesi_cache DUT (
		.clk(clk), .arst_n(arst_n),
		.req_valid(req_valid), .req_ready(req_ready), .req_op(req_op), .req_addr(req_addr),
		.resp_valid(resp_valid), .resp_ready(resp_ready), .resp_op(resp_op),
		.resp_hit(resp_hit), .resp_way(resp_way), .resp_snoop(resp_snoop),
		.resp_state(resp_state), .resp_addr(resp_addr),
		.hit_count(hit_count), .miss_count(miss_count)
	);

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// tag from a small pool, set 0..15, bits 1:0 pick the bus answer
	function automatic logic [31:0] make_addr(input int tag_idx, input int set,
		input logic [1:0] low);
		return {22'h3000 + 22'(tag_idx), 4'(set), 4'h0, low};
	endfunction

	////////////////////////////////////////////////////////////
	// compare tasks
	////////////////////////////////////////////////////////////
	task automatic check_state(input string name, input cache_pkg::mesi_e exp,
		input cache_pkg::mesi_e got);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("Fail t=%0t %s exp=%s got=%s", $time, name, exp.name(), got.name());
		end
	endtask

	task automatic check_snoop(input string name, input cache_pkg::snoop_e exp,
		input cache_pkg::snoop_e got);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("Fail t=%0t %s exp=%s got=%s", $time, name, exp.name(), got.name());
		end
	endtask

	task automatic check_count(input string name, input int exp, input logic [15:0] got);
		checks++;
		if (got !== 16'(exp))
		begin
			errors++;
			$display("Fail t=%0t %s exp=%0d got=%0d", $time, name, exp, got);
		end
	endtask

	task automatic check_resp(input cache_pkg::resp_t exp, input cache_pkg::resp_t got);
		checks++;
		if (got.op !== exp.op || got.hit !== exp.hit || got.way !== exp.way
			|| got.addr !== exp.addr)
		begin
			errors++;
			$display("Fail t=%0t resp op/hit/way/addr exp=%s/%0d/%0d/%h got=%s/%0d/%0d/%h",
				$time, exp.op.name(), exp.hit, exp.way, exp.addr,
				got.op.name(), got.hit, got.way, got.addr);
		end
		check_snoop("resp_snoop", exp.snoop, got.snoop);
		check_state("resp_state", exp.state, got.state);
	endtask

	////////////////////////////////////////////////////////////
	// reference model
	////////////////////////////////////////////////////////////
	task automatic model_touch(input int s, input int w);
		int old;
		old = m_age[s][w];
		for (int v = 0; v < cache_pkg::NUM_WAYS; v++)
		begin
			if (v == w)
				m_age[s][v] = cache_pkg::NUM_WAYS - 1;
			else if (m_age[s][v] > old)
				m_age[s][v] = m_age[s][v] - 1;
		end
	endtask

	task automatic model_op(input cache_pkg::cache_op_e op, input logic [31:0] addr);
		int s;
		int hw;
		int vic;
		logic hit;
		cache_pkg::tag_t t;
		cache_pkg::snoop_e bus;
		cache_pkg::resp_t e;
		s = int'(addr[9:6]);
		t = addr[31:10];
		e.op = op;
		e.addr = addr;
		if (op == cache_pkg::CLEAR_ALL)
		begin
			for (int i = 0; i < cache_pkg::NUM_SETS; i++)
				for (int w = 0; w < cache_pkg::NUM_WAYS; w++)
				begin
					m_state[i][w] = cache_pkg::INVALID;
					m_age[i][w] = w;
				end
			e.hit = 1'b0;
			e.way = 3'd0;
			e.snoop = cache_pkg::SNP_MISS;
			e.state = cache_pkg::INVALID;
			exp_q.push_back(e);
			return;
		end
		hit = 1'b0;
		hw = 0;
		vic = -1;
		// lowest invalid way first, else age zero
		for (int w = cache_pkg::NUM_WAYS - 1; w >= 0; w--)
		begin
			if (m_state[s][w] != cache_pkg::INVALID && m_tag[s][w] == t)
			begin
				hit = 1'b1;
				hw = w;
			end
			if (m_state[s][w] == cache_pkg::INVALID)
				vic = w;
		end
		if (vic < 0)
			for (int w = 0; w < cache_pkg::NUM_WAYS; w++)
				if (m_age[s][w] == 0)
					vic = w;
		case (addr[1:0])
			2'b00:   bus = cache_pkg::SNP_HIT;
			2'b10:   bus = cache_pkg::SNP_HITM;
			default: bus = cache_pkg::SNP_MISS;
		endcase
		e.hit = hit;
		e.way = hit ? 3'(hw) : 3'(vic);
		if (op inside {cache_pkg::READ_DATA, cache_pkg::WRITE_DATA, cache_pkg::READ_INSTR})
		begin
			e.snoop = bus;
			if (op == cache_pkg::WRITE_DATA)
				e.state = cache_pkg::MODIFIED;
			else if (hit)
				e.state = m_state[s][hw];
			else
				e.state = (bus == cache_pkg::SNP_MISS) ? cache_pkg::EXCLUSIVE : cache_pkg::SHARED;
			if (hit)
				m_hits++;
			else
				m_misses++;
			m_tag[s][int'(e.way)] = t;
			m_state[s][int'(e.way)] = e.state;
			model_touch(s, int'(e.way));
		end
		else
		begin
			if (!hit)
				e.snoop = cache_pkg::SNP_MISS;
			else if (m_state[s][hw] == cache_pkg::MODIFIED)
				e.snoop = cache_pkg::SNP_HITM;
			else
				e.snoop = cache_pkg::SNP_HIT;
			if (!hit || op == cache_pkg::SNOOP_RWIM)
				e.state = cache_pkg::INVALID;
			else if (op == cache_pkg::SNOOP_READ)
				e.state = cache_pkg::SHARED;
			else if (m_state[s][hw] == cache_pkg::SHARED)
				e.state = cache_pkg::INVALID;
			else
				e.state = m_state[s][hw];
			if (hit)
				m_state[s][hw] = e.state;
		end
		exp_q.push_back(e);
	endtask

	////////////////////////////////////////////////////////////
	// drivers and monitor
	////////////////////////////////////////////////////////////
	task automatic send(input cache_pkg::cache_op_e op, input logic [31:0] addr);
		@(posedge clk);
		#2;
		req_valid = 1'b1;
		req_op = op;
		req_addr = addr;
		@(negedge clk);
		while (!req_ready)
			@(negedge clk);
		model_op(op, addr);
		@(posedge clk);
		#2 req_valid = 1'b0;
	endtask

	// waits for every response, then checks the counters
	task automatic end_test(input string name, input int err_start);
		@(negedge clk);
		while (exp_q.size() != 0)
			@(negedge clk);
		check_count("hit_count", m_hits, hit_count);
		check_count("miss_count", m_misses, miss_count);
		tests++;
		$display("test %s done with %0d errors", name, errors - err_start);
	endtask

	always @(posedge clk)
	begin
		#2;
		rdy_rng = xorshift(rdy_rng);
		// low one time in four
		resp_ready = !hold && (rdy_rng[1:0] != 2'b00);
	end

	always @(negedge clk)
	begin
		if (arst_n && resp_valid && resp_ready)
		begin
			if (exp_q.size() == 0)
			begin
				errors++;
				$display("a response came out with no request waiting for it at %0t", $time);
			end
			else
				check_resp(exp_q.pop_front(), {resp_op, resp_hit, resp_way, resp_snoop,
					resp_state, resp_addr});
		end
	end

	// bound on the whole run
	initial
	begin
		#(N_REQ * 40 * 40 + N_CLR * cache_pkg::NUM_SETS * 40 * 40);
		$display("watchdog expired before all tests finished");
		$display("STATUS: FAIL");
		$finish;
	end

	////////////////////////////////////////////////////////////
	// test sequence
	////////////////////////////////////////////////////////////
	initial
	begin
		int e0;
		int acc;
		int cyc;
		int k;
		logic refused;
		cache_pkg::cache_op_e op;
		req_valid = 1'b0;
		req_op = cache_pkg::READ_DATA;
		req_addr = '0;
		resp_ready = 1'b0;
		hold = 1'b0;
		errors = 0;
		checks = 0;
		tests = 0;
		m_hits = 0;
		m_misses = 0;
		rng = 32'h702c;
		rdy_rng = xorshift(32'h702c);
		for (int s = 0; s < cache_pkg::NUM_SETS; s++)
			for (int w = 0; w < cache_pkg::NUM_WAYS; w++)
			begin
				m_tag[s][w] = '0;
				m_state[s][w] = cache_pkg::INVALID;
				m_age[s][w] = w;
			end
		@(posedge arst_n);

		// read miss fills S or E, hits keep state
		e0 = errors;
		send(cache_pkg::READ_DATA, make_addr(0, 8, 2'b00));
		send(cache_pkg::READ_DATA, make_addr(1, 8, 2'b01));
		send(cache_pkg::READ_INSTR, make_addr(2, 8, 2'b10));
		send(cache_pkg::READ_DATA, make_addr(0, 8, 2'b11));
		send(cache_pkg::READ_INSTR, make_addr(1, 8, 2'b00));
		end_test("read_hit_miss", e0);

		e0 = errors;
		send(cache_pkg::WRITE_DATA, make_addr(3, 8, 2'b01));
		send(cache_pkg::WRITE_DATA, make_addr(0, 8, 2'b10));
		send(cache_pkg::READ_DATA, make_addr(3, 8, 2'b00));
		end_test("write", e0);

		// M, E and S lines in one set, then every snoop
		e0 = errors;
		send(cache_pkg::WRITE_DATA, make_addr(0, 9, 2'b00));
		send(cache_pkg::READ_DATA, make_addr(1, 9, 2'b01));
		send(cache_pkg::READ_DATA, make_addr(2, 9, 2'b00));
		send(cache_pkg::SNOOP_INVAL, make_addr(1, 9, 2'b00));
		send(cache_pkg::SNOOP_READ, make_addr(0, 9, 2'b00));
		send(cache_pkg::SNOOP_READ, make_addr(1, 9, 2'b00));
		send(cache_pkg::SNOOP_INVAL, make_addr(2, 9, 2'b00));
		send(cache_pkg::WRITE_DATA, make_addr(2, 9, 2'b00));
		send(cache_pkg::SNOOP_RWIM, make_addr(2, 9, 2'b00));
		send(cache_pkg::SNOOP_RWIM, make_addr(1, 9, 2'b00));
		send(cache_pkg::SNOOP_READ, make_addr(7, 9, 2'b00));
		end_test("snoops", e0);

		// way 0 retouched, so the ninth tag evicts way 1
		e0 = errors;
		for (int i = 0; i < 8; i++)
			send(cache_pkg::READ_DATA, make_addr(i, 10, 2'b01));
		send(cache_pkg::READ_DATA, make_addr(0, 10, 2'b01));
		send(cache_pkg::READ_DATA, make_addr(8, 10, 2'b01));
		send(cache_pkg::READ_DATA, make_addr(9, 10, 2'b01));
		end_test("lru_order", e0);

		e0 = errors;
		for (int i = 0; i < N_RAND; i++)
		begin
			rng = xorshift(rng);
			case (rng[2:0])
				3'd0, 3'd1: op = cache_pkg::READ_DATA;
				3'd2, 3'd3: op = cache_pkg::WRITE_DATA;
				3'd4:       op = cache_pkg::READ_INSTR;
				3'd5:       op = cache_pkg::SNOOP_INVAL;
				3'd6:       op = cache_pkg::SNOOP_READ;
				default:    op = cache_pkg::SNOOP_RWIM;
			endcase
			send(op, make_addr(int'(rng[15:8]) % 24, int'(rng[17:16]), rng[21:20]));
		end
		end_test("random_mix", e0);

		// everything misses again, from way 0
		e0 = errors;
		send(cache_pkg::CLEAR_ALL, 32'h0);
		send(cache_pkg::READ_DATA, make_addr(0, 8, 2'b00));
		send(cache_pkg::WRITE_DATA, make_addr(0, 9, 2'b01));
		send(cache_pkg::READ_INSTR, make_addr(8, 10, 2'b11));
		send(cache_pkg::READ_DATA, make_addr(5, 10, 2'b11));
		end_test("clear", e0);

		// queue stalls, six requests fit in flight
		e0 = errors;
		hold = 1'b1;
		repeat (2) @(posedge clk);
		#2;
		acc = 0;
		k = 0;
		refused = 1'b0;
		while (!refused && k < 8)
		begin
			req_valid = 1'b1;
			req_op = cache_pkg::READ_DATA;
			req_addr = make_addr(k, 11, 2'b01);
			cyc = 0;
			@(negedge clk);
			while (!req_ready && cyc < 12)
			begin
				cyc++;
				@(negedge clk);
			end
			if (req_ready)
			begin
				model_op(req_op, req_addr);
				acc++;
				k++;
				@(posedge clk);
				#2;
			end
			else
				refused = 1'b1;
		end
		if (!refused || acc != 6)
		begin
			errors++;
			$display("req_ready stayed high too long or fell early, %0d requests taken", acc);
		end
		hold = 1'b0;
		if (refused)
		begin
			@(negedge clk);
			while (!req_ready)
				@(negedge clk);
			model_op(req_op, req_addr);
			@(posedge clk);
			#2;
		end
		req_valid = 1'b0;
		end_test("backpressure", e0);

		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

//--- dv/tb_clk_gen.sv
`timescale 1ns/100ps

module tb_clk_gen (
	output logic clk,
	output logic arst_n
);

	// 40 ns period
	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// reset held for five rising edges
	initial
	begin
		arst_n = 1'b0;
		repeat (5) @(posedge clk);
		#2 arst_n = 1'b1;
	end

endmodule

//--- hdl/l2_mesi_cache.sv
`timescale 1ns/100ps

module l2_mesi_cache (
	input  logic                          clk,
	input  logic                          arst_n,
	// request side
	input  logic                          req_valid,
	output logic                          req_ready,
	input  cache_pkg::cache_op_e          req_op,
	input  logic [cache_pkg::ADDR_W-1:0]  req_addr,
	// response side
	output logic                          resp_valid,
	input  logic                          resp_ready,
	output cache_pkg::cache_op_e          resp_op,
	output logic                          resp_hit,
	output cache_pkg::way_t               resp_way,
	output cache_pkg::snoop_e             resp_snoop,
	output cache_pkg::mesi_e              resp_state,
	output logic [cache_pkg::ADDR_W-1:0]  resp_addr,
	// running L1 statistics
	output logic [cache_pkg::CNT_W-1:0]   hit_count,
	output logic [cache_pkg::CNT_W-1:0]   miss_count
);

	logic                         cap_valid;
	logic                         cap_ready;
	cache_pkg::cache_op_e         cap_op;
	cache_pkg::index_t            cap_set;
	cache_pkg::tag_t              cap_tag;
	logic [cache_pkg::ADDR_W-1:0] cap_addr;
	logic                         touch;
	cache_pkg::index_t            touch_set;
	cache_pkg::way_t              touch_way;
	logic                         reset_set;
	cache_pkg::way_t              lru_way;
	logic                         push;
	cache_pkg::resp_t             push_data;
	logic                         full;
	cache_pkg::resp_t             resp_data;

	dir_access_if dir ();

	req_capture u_cap (
		.clk(clk), .arst_n(arst_n),
		.req_valid(req_valid), .req_op(req_op), .req_addr(req_addr), .req_ready(req_ready),
		.cap_valid(cap_valid), .cap_op(cap_op), .cap_set(cap_set), .cap_tag(cap_tag),
		.cap_addr(cap_addr), .cap_ready(cap_ready)
	);

	mesi_ctrl u_ctrl (
		.clk(clk), .arst_n(arst_n),
		.cap_valid(cap_valid), .cap_op(cap_op), .cap_set(cap_set), .cap_tag(cap_tag),
		.cap_addr(cap_addr), .cap_ready(cap_ready),
		.dir(dir),
		.touch(touch), .touch_set(touch_set), .touch_way(touch_way),
		.reset_set(reset_set), .lru_way(lru_way),
		.push(push), .push_data(push_data), .full(full),
		.hit_count(hit_count), .miss_count(miss_count)
	);

	tag_state_array u_array (.clk(clk), .arst_n(arst_n), .dir(dir));

	lru_ages u_lru (
		.clk(clk), .arst_n(arst_n), .touch(touch), .touch_set(touch_set),
		.touch_way(touch_way), .reset_set(reset_set), .lru_way(lru_way)
	);

	resp_fifo u_fifo (
		.clk(clk), .arst_n(arst_n), .push(push), .push_data(push_data), .full(full),
		.resp_valid(resp_valid), .resp_ready(resp_ready), .resp_data(resp_data)
	);

	// response word onto the flat ports
	assign resp_op    = resp_data.op;
	assign resp_hit   = resp_data.hit;
	assign resp_way   = resp_data.way;
	assign resp_snoop = resp_data.snoop;
	assign resp_state = resp_data.state;
	assign resp_addr  = resp_data.addr;

endmodule

//--- hdl/resp_fifo.sv
`timescale 1ns/100ps

module resp_fifo (
	input  logic              clk,
	input  logic              arst_n,
	input  logic              push,
	input  cache_pkg::resp_t  push_data,
	output logic              full,
	output logic              resp_valid,
	input  logic              resp_ready,
	output cache_pkg::resp_t  resp_data
);

	cache_pkg::resp_t mem [cache_pkg::RESP_DEPTH];

	logic [cache_pkg::RESP_PTR_W-1:0] wr_ptr;
	logic [cache_pkg::RESP_PTR_W-1:0] rd_ptr;
	// one extra bit to tell full from empty
	logic [cache_pkg::RESP_PTR_W:0]   count;
	logic                             pop;

	assign pop        = resp_valid && resp_ready;
	assign resp_valid = (count != '0);
	assign full       = (count == (cache_pkg::RESP_PTR_W + 1)'(cache_pkg::RESP_DEPTH));
	assign resp_data  = mem[rd_ptr];

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			// pointers wrap on their own
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (push)
			mem[wr_ptr] <= push_data;
	end

	// producer holds off while the queue is full
	assert property (@(posedge clk) disable iff (!arst_n) push |-> !full);

endmodule

//--- hdl/mesi_ctrl.sv
`timescale 1ns/100ps

module mesi_ctrl (
	input  logic                            clk,
	input  logic                            arst_n,
	input  logic                            cap_valid,
	input  cache_pkg::cache_op_e            cap_op,
	input  cache_pkg::index_t               cap_set,
	input  cache_pkg::tag_t                 cap_tag,
	input  logic [cache_pkg::ADDR_W-1:0]    cap_addr,
	output logic                            cap_ready,
	dir_access_if.ctrl                      dir,
	output logic                            touch,
	output cache_pkg::index_t               touch_set,
	output cache_pkg::way_t                 touch_way,
	output logic                            reset_set,
	input  cache_pkg::way_t                 lru_way,
	output logic                            push,
	output cache_pkg::resp_t                push_data,
	input  logic                            full,
	output logic [cache_pkg::CNT_W-1:0]     hit_count,
	output logic [cache_pkg::CNT_W-1:0]     miss_count
);

	cache_pkg::ctrl_state_e       state;
	cache_pkg::index_t            clr_cnt;

	// request held for LOOKUP and UPDATE
	cache_pkg::cache_op_e         op_q;
	cache_pkg::index_t            set_q;
	cache_pkg::tag_t              tag_q;
	logic [cache_pkg::ADDR_W-1:0] addr_q;
	logic                         hit_q;
	cache_pkg::way_t              hit_way_q;
	cache_pkg::mesi_e             hit_state_q;
	cache_pkg::way_t              victim_q;

	logic                         fire;
	logic                         is_l1;
	logic                         is_snoop;
	cache_pkg::snoop_e            bus_snp;
	cache_pkg::snoop_e            own_snp;
	cache_pkg::way_t              upd_way;
	cache_pkg::mesi_e             new_state;

	////////////////////////////////////////////////////////////
	// next line state and snoop answers
	////////////////////////////////////////////////////////////
	always_comb
	begin
		is_l1    = op_q inside {cache_pkg::READ_DATA, cache_pkg::WRITE_DATA,
			cache_pkg::READ_INSTR};
		is_snoop = op_q inside {cache_pkg::SNOOP_INVAL, cache_pkg::SNOOP_READ,
			cache_pkg::SNOOP_RWIM};
		// other caches answer through address bits 1:0
		case (addr_q[1:0])
			2'b00:   bus_snp = cache_pkg::SNP_HIT;
			2'b10:   bus_snp = cache_pkg::SNP_HITM;
			default: bus_snp = cache_pkg::SNP_MISS;
		endcase
		// our answer to a snoop
		if (!hit_q)
			own_snp = cache_pkg::SNP_MISS;
		else if (hit_state_q == cache_pkg::MODIFIED)
			own_snp = cache_pkg::SNP_HITM;
		else
			own_snp = cache_pkg::SNP_HIT;
		upd_way   = hit_q ? hit_way_q : victim_q;
		new_state = hit_q ? hit_state_q : cache_pkg::INVALID;
		case (op_q)
			cache_pkg::READ_DATA, cache_pkg::READ_INSTR:
			begin
				// fill shared when someone else holds it
				if (!hit_q)
					new_state = (bus_snp == cache_pkg::SNP_MISS) ?
						cache_pkg::EXCLUSIVE : cache_pkg::SHARED;
			end
			cache_pkg::WRITE_DATA:
				new_state = cache_pkg::MODIFIED;
			cache_pkg::SNOOP_READ:
			begin
				// M and E give up ownership
				if (hit_q)
					new_state = cache_pkg::SHARED;
			end
			cache_pkg::SNOOP_RWIM:
				new_state = cache_pkg::INVALID;
			cache_pkg::SNOOP_INVAL:
			begin
				if (hit_q && hit_state_q == cache_pkg::SHARED)
					new_state = cache_pkg::INVALID;
			end
			default:
				new_state = cache_pkg::INVALID;
		endcase
	end

	// UPDATE completes only with room in the queue
	assign fire      = (state == cache_pkg::UPDATE) && !full;
	assign cap_ready = (state == cache_pkg::IDLE);

	////////////////////////////////////////////////////////////
	// array and LRU side
	////////////////////////////////////////////////////////////
	assign dir.set      = (state == cache_pkg::CLEAR) ? clr_cnt : set_q;
	assign dir.tag      = tag_q;
	assign dir.wr_en    = fire && (is_l1 || (is_snoop && hit_q));
	assign dir.wr_way   = upd_way;
	assign dir.wr_tag   = tag_q;
	assign dir.wr_state = new_state;
	assign dir.clr_set  = (state == cache_pkg::CLEAR);

	// snoops leave LRU alone
	assign touch     = fire && is_l1;
	assign touch_set = dir.set;
	assign touch_way = upd_way;
	assign reset_set = (state == cache_pkg::CLEAR);

	assign push            = fire;
	assign push_data.op    = op_q;
	assign push_data.hit   = hit_q;
	assign push_data.way   = upd_way;
	assign push_data.snoop = is_l1 ? bus_snp : own_snp;
	assign push_data.state = new_state;
	assign push_data.addr  = addr_q;

	////////////////////////////////////////////////////////////
	// sequencing
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state      <= cache_pkg::IDLE;
			clr_cnt    <= '0;
			hit_count  <= '0;
			miss_count <= '0;
		end
		else
		begin
			case (state)
				cache_pkg::IDLE:
				begin
					clr_cnt <= '0;
					if (cap_valid)
						state <= (cap_op == cache_pkg::CLEAR_ALL) ?
							cache_pkg::CLEAR : cache_pkg::LOOKUP;
				end
				cache_pkg::LOOKUP:
					state <= cache_pkg::UPDATE;
				cache_pkg::UPDATE:
				begin
					if (!full)
						state <= cache_pkg::IDLE;
				end
				default:
				begin
					// one set per cycle, last one moves on to the push
					clr_cnt <= clr_cnt + 1'b1;
					if (clr_cnt == cache_pkg::INDEX_W'(cache_pkg::NUM_SETS - 1))
						state <= cache_pkg::UPDATE;
				end
			endcase
			// counters survive a clear
			if (fire && is_l1)
			begin
				if (hit_q)
					hit_count <= hit_count + 1'b1;
				else
					miss_count <= miss_count + 1'b1;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (state == cache_pkg::IDLE && cap_valid)
		begin
			op_q      <= cap_op;
			set_q     <= cap_set;
			tag_q     <= cap_tag;
			addr_q    <= cap_addr;
			// clear-all skips LOOKUP and reports a miss on way 0
			hit_q     <= 1'b0;
			hit_way_q <= '0;
			victim_q  <= '0;
		end
		else if (state == cache_pkg::LOOKUP)
		begin
			hit_q       <= dir.hit;
			hit_way_q   <= dir.hit_way;
			hit_state_q <= dir.hit_state;
			// empty way first, then the oldest
			victim_q    <= dir.inv_found ? dir.inv_way : lru_way;
		end
	end

	// a hit never lands on an empty line
	assert property (@(posedge clk) disable iff (!arst_n)
		(state == cache_pkg::LOOKUP && dir.hit) |-> (dir.hit_state != cache_pkg::INVALID));

endmodule

//--- hdl/lru_ages.sv
`timescale 1ns/100ps

module lru_ages (
	input  logic               clk,
	input  logic               arst_n,
	input  logic               touch,
	input  cache_pkg::index_t  touch_set,
	input  cache_pkg::way_t    touch_way,
	input  logic               reset_set,
	output cache_pkg::way_t    lru_way
);

	// highest age is most recently used
	cache_pkg::way_t age [cache_pkg::NUM_SETS][cache_pkg::NUM_WAYS];

	logic [cache_pkg::NUM_WAYS-1:0] zero_vec;

	// victim is the way at age zero
	always_comb
	begin
		lru_way = '0;
		for (int w = cache_pkg::NUM_WAYS - 1; w >= 0; w--)
		begin
			zero_vec[w] = (age[touch_set][w] == '0);
			if (zero_vec[w])
				lru_way = cache_pkg::WAY_W'(w);
		end
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			// way i starts at age i
			for (int s = 0; s < cache_pkg::NUM_SETS; s++)
				for (int w = 0; w < cache_pkg::NUM_WAYS; w++)
					age[s][w] <= cache_pkg::WAY_W'(w);
		end
		else if (reset_set)
		begin
			for (int w = 0; w < cache_pkg::NUM_WAYS; w++)
				age[touch_set][w] <= cache_pkg::WAY_W'(w);
		end
		else if (touch)
		begin
			for (int w = 0; w < cache_pkg::NUM_WAYS; w++)
			begin
				if (cache_pkg::WAY_W'(w) == touch_way)
					age[touch_set][w] <= cache_pkg::WAY_W'(cache_pkg::NUM_WAYS - 1);
				// only the ways newer than the touched one slide down
				else if (age[touch_set][w] > age[touch_set][touch_way])
					age[touch_set][w] <= age[touch_set][w] - 1'b1;
			end
		end
	end

	// ages of a set stay a permutation
	assert property (@(posedge clk) disable iff (!arst_n) $onehot(zero_vec));

endmodule

//--- hdl/tag_state_array.sv
`timescale 1ns/100ps

module tag_state_array (
	input  logic         clk,
	input  logic         arst_n,
	dir_access_if.array  dir
);

	cache_pkg::tag_t  tags   [cache_pkg::NUM_SETS][cache_pkg::NUM_WAYS];
	cache_pkg::mesi_e states [cache_pkg::NUM_SETS][cache_pkg::NUM_WAYS];

	logic [cache_pkg::NUM_WAYS-1:0] hit_vec;
	logic [cache_pkg::NUM_WAYS-1:0] inv_vec;

	////////////////////////////////////////////////////////////
	// lookup
	////////////////////////////////////////////////////////////
	always_comb
	begin
		dir.hit       = 1'b0;
		dir.hit_way   = '0;
		dir.hit_state = cache_pkg::INVALID;
		dir.inv_found = 1'b0;
		dir.inv_way   = '0;
		// walk down so the lowest way wins
		for (int w = cache_pkg::NUM_WAYS - 1; w >= 0; w--)
		begin
			inv_vec[w] = (states[dir.set][w] == cache_pkg::INVALID);
			hit_vec[w] = !inv_vec[w] && (tags[dir.set][w] == dir.tag);
			if (hit_vec[w])
			begin
				dir.hit       = 1'b1;
				dir.hit_way   = cache_pkg::WAY_W'(w);
				dir.hit_state = states[dir.set][w];
			end
			if (inv_vec[w])
			begin
				dir.inv_found = 1'b1;
				dir.inv_way   = cache_pkg::WAY_W'(w);
			end
		end
	end

	////////////////////////////////////////////////////////////
	// update
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			for (int s = 0; s < cache_pkg::NUM_SETS; s++)
			begin
				for (int w = 0; w < cache_pkg::NUM_WAYS; w++)
				begin
					tags[s][w]   <= '0;
					states[s][w] <= cache_pkg::INVALID;
				end
			end
		end
		else if (dir.clr_set)
		begin
			// whole set at once, tags left behind
			for (int w = 0; w < cache_pkg::NUM_WAYS; w++)
				states[dir.set][w] <= cache_pkg::INVALID;
		end
		else if (dir.wr_en)
		begin
			tags[dir.set][dir.wr_way]   <= dir.wr_tag;
			states[dir.set][dir.wr_way] <= dir.wr_state;
		end
	end

	// a tag lives in one way of a set only
	assert property (@(posedge clk) disable iff (!arst_n) $onehot0(hit_vec));

endmodule

//--- hdl/req_capture.sv
`timescale 1ns/100ps

module req_capture (
	input  logic                           clk,
	input  logic                           arst_n,
	input  logic                           req_valid,
	input  cache_pkg::cache_op_e           req_op,
	input  logic [cache_pkg::ADDR_W-1:0]   req_addr,
	output logic                           req_ready,
	output logic                           cap_valid,
	output cache_pkg::cache_op_e           cap_op,
	output cache_pkg::index_t              cap_set,
	output cache_pkg::tag_t                cap_tag,
	output logic [cache_pkg::ADDR_W-1:0]   cap_addr,
	input  logic                           cap_ready
);

	cache_pkg::cache_op_e         op_q;
	logic [cache_pkg::ADDR_W-1:0] addr_q;

	// free slot, or the held item leaves this cycle
	assign req_ready = !cap_valid || cap_ready;

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			cap_valid <= 1'b0;
		else if (req_valid && req_ready)
			cap_valid <= 1'b1;
		else if (cap_ready)
			cap_valid <= 1'b0;
	end

	always_ff @(posedge clk)
	begin
		if (req_valid && req_ready)
		begin
			op_q   <= req_op;
			addr_q <= req_addr;
		end
	end

	assign cap_op   = op_q;
	assign cap_addr = addr_q;
	// index above the offset, tag above the index
	assign cap_set  = addr_q[cache_pkg::OFFSET_W +: cache_pkg::INDEX_W];
	assign cap_tag  = addr_q[cache_pkg::OFFSET_W + cache_pkg::INDEX_W +: cache_pkg::TAG_W];

	// a refused request stays on the bus unchanged
	assert property (@(posedge clk) disable iff (!arst_n)
		(req_valid && !req_ready) |=> (req_valid && $stable(req_op) && $stable(req_addr)));

endmodule

//--- hdl/dir_access_if.sv
`timescale 1ns/100ps

interface dir_access_if;

	// lookup address, driven by the controller
	cache_pkg::index_t set;
	cache_pkg::tag_t   tag;

	// single-way write port
	logic              wr_en;
	cache_pkg::way_t   wr_way;
	cache_pkg::tag_t   wr_tag;
	cache_pkg::mesi_e  wr_state;
	// invalidate all ways of set
	logic              clr_set;

	// combinational lookup results
	logic              hit;
	cache_pkg::way_t   hit_way;
	cache_pkg::mesi_e  hit_state;
	logic              inv_found;
	cache_pkg::way_t   inv_way;

	modport ctrl (
		output set, tag, wr_en, wr_way, wr_tag, wr_state, clr_set,
		input  hit, hit_way, hit_state, inv_found, inv_way
	);

	modport array (
		input  set, tag, wr_en, wr_way, wr_tag, wr_state, clr_set,
		output hit, hit_way, hit_state, inv_found, inv_way
	);

endinterface

//--- hdl/cache_pkg.sv
package cache_pkg;

	////////////////////////////////////////////////////////////
	// geometry
	////////////////////////////////////////////////////////////
	localparam int ADDR_W     = 32;
	localparam int NUM_SETS   = 16;
	localparam int NUM_WAYS   = 8;
	// address 5:0 is the line offset
	localparam int OFFSET_W   = 6;
	// address 9:6
	localparam int INDEX_W    = 4;
	// address 31:10
	localparam int TAG_W      = 22;
	localparam int WAY_W      = 3;
	localparam int RESP_DEPTH = 4;
	localparam int RESP_PTR_W = 2;
	// hit and miss counter width
	localparam int CNT_W      = 16;

	////////////////////////////////////////////////////////////
	// encodings
	////////////////////////////////////////////////////////////
	// trace op numbers, 5 7 and 9 not handled
	typedef enum logic [3:0] {
		READ_DATA   = 4'd0,
		WRITE_DATA  = 4'd1,
		READ_INSTR  = 4'd2,
		SNOOP_INVAL = 4'd3,
		SNOOP_READ  = 4'd4,
		SNOOP_RWIM  = 4'd6,
		CLEAR_ALL   = 4'd8
	} cache_op_e;

	typedef enum logic [1:0] {MODIFIED, EXCLUSIVE, SHARED, INVALID} mesi_e;

	typedef enum logic [1:0] {SNP_HIT, SNP_HITM, SNP_MISS} snoop_e;

	typedef enum logic [1:0] {IDLE, LOOKUP, UPDATE, CLEAR} ctrl_state_e;

	typedef logic [TAG_W-1:0]   tag_t;
	typedef logic [INDEX_W-1:0] index_t;
	typedef logic [WAY_W-1:0]   way_t;

	// one response word per request
	typedef struct packed {
		cache_op_e         op;
		logic              hit;
		way_t              way;
		// bus answer seen (L1 ops) or answer given (snoops)
		snoop_e            snoop;
		// line state after the op
		mesi_e             state;
		logic [ADDR_W-1:0] addr;
	} resp_t;

endpackage
